// File: dma_req_frontend.f
logic/dma_req_pkg.sv
logic/dma_req_ctrl.sv
logic/req_queue.sv
logic/request_splitter.sv
logic/dma_req_frontend.sv
sim/tb_dma_req_frontend.sv

// File: logic/dma_req_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

// apb register file for the request front end
module dma_req_ctrl (
    input  wire logic                  aclk,
    input  wire logic                  aresetn,

    // apb slave
    input  wire dma_req_pkg::apb_req_t apb_req,
    output dma_req_pkg::apb_rsp_t      apb_rsp,

    // event pulses and status from the datapath
    input  wire logic                  req_taken,
    input  wire logic                  frag_sent,
    input  wire logic                  busy,
    input  wire logic [2:0]            q_count,

    // configuration to the splitter
    output logic                       enable,
    output logic [27:0]                max_len_mask
);

    import dma_req_pkg::*;

    // access phase qualifiers
    logic        access;
    logic        wr_access;

    // read mux result and offset hit
    logic [31:0] rd_data;
    logic        addr_hit;

    // running counters
    logic [31:0] req_count;
    logic [31:0] frag_count;

    // status word
    logic [31:0] status;

    // second cycle of a transfer
    assign access    = apb_req.psel & apb_req.penable;
    assign wr_access = access & apb_req.pwrite;

    // busy in bit 0, queue fill in bits 6:4
    assign status = {25'd0, q_count, 3'd0, busy};

    // writable registers
    // only CTRL and MAX_MASK, everything else drops the write
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            enable       <= 1'b1;
            max_len_mask <= MAX_MASK_RESET;
        end else if (wr_access) begin
            case (apb_req.paddr)
                REG_CTRL: begin
                    enable <= apb_req.pwdata[0];
                end
                REG_MAX_MASK: begin
                    max_len_mask <= apb_req.pwdata[27:0];
                end
                default: begin
                    // read-only or unmapped offset
                end
            endcase
        end
    end

    // accepted request counter, wraps at 2^32
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            req_count <= 32'd0;
        end else if (req_taken) begin
            req_count <= req_count + 32'd1;
        end
    end

    // issued fragment counter, wraps at 2^32
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            frag_count <= 32'd0;
        end else if (frag_sent) begin
            frag_count <= frag_count + 32'd1;
        end
    end

    // read decode
    // also flags unmapped offsets for the error response
    always_comb begin
        rd_data  = 32'd0;
        addr_hit = 1'b1;
        case (apb_req.paddr)
            REG_CTRL: begin
                rd_data = {31'd0, enable};
            end
            REG_MAX_MASK: begin
                rd_data = {4'd0, max_len_mask};
            end
            REG_STATUS: begin
                rd_data = status;
            end
            REG_REQ_COUNT: begin
                rd_data = req_count;
            end
            REG_FRAG_COUNT: begin
                rd_data = frag_count;
            end
            default: begin
                addr_hit = 1'b0;
            end
        endcase
    end

    // zero wait state slave
    // read data and error only during the access phase
    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.prdata  = access ? rd_data : 32'd0;
        apb_rsp.pslverr = access & ~addr_hit;
    end

endmodule

`default_nettype wire

// File: logic/dma_req_frontend.sv
`timescale 1ns/100ps
`default_nettype none

// dma request front end
// host requests are queued, then split into bounded fragments
module dma_req_frontend (
    input  wire logic                  aclk,
    input  wire logic                  aresetn,

    // configuration and status
    input  wire dma_req_pkg::apb_req_t apb_req,
    output dma_req_pkg::apb_rsp_t      apb_rsp,

    // host request stream
    input  wire logic                  req_in_valid,
    output logic                       req_in_ready,
    input  wire dma_req_pkg::req_t     req_in_data,

    // fragment stream
    output logic                       frag_valid,
    input  wire logic                  frag_ready,
    output dma_req_pkg::req_t          frag_data
);

    import dma_req_pkg::*;

    // queue head to splitter
    logic        q_valid;
    logic        q_ready;
    req_t        q_data;
    logic [2:0]  q_count;

    // control to splitter
    logic        enable;
    logic [27:0] max_len_mask;

    // splitter events back to control
    logic        req_taken;
    logic        frag_sent;
    logic        busy;

    dma_req_ctrl i_ctrl (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .req_taken    (req_taken),
        .frag_sent    (frag_sent),
        .busy         (busy),
        .q_count      (q_count),
        .enable       (enable),
        .max_len_mask (max_len_mask)
    );

    // decouples the host from a stalled splitter
    req_queue i_queue (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (req_in_valid),
        .in_data   (req_in_data),
        .in_ready  (req_in_ready),
        .out_valid (q_valid),
        .out_data  (q_data),
        .out_ready (q_ready),
        .count     (q_count)
    );

    request_splitter i_splitter (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .max_len_mask (max_len_mask),
        .enable       (enable),
        .in_valid     (q_valid),
        .in_data      (q_data),
        .in_ready     (q_ready),
        .out_valid    (frag_valid),
        .out_data     (frag_data),
        .out_ready    (frag_ready),
        .req_taken    (req_taken),
        .frag_sent    (frag_sent),
        .busy         (busy)
    );

endmodule

`default_nettype wire

// File: logic/dma_req_pkg.sv
`default_nettype none

// shared types and constants for the dma request front end
package dma_req_pkg;

    // request queue size in entries
    localparam int QUEUE_DEPTH = 4;

    // apb register map, byte offsets
    localparam logic [7:0] REG_CTRL       = 8'h00;
    localparam logic [7:0] REG_MAX_MASK   = 8'h04;
    localparam logic [7:0] REG_STATUS     = 8'h08;
    localparam logic [7:0] REG_REQ_COUNT  = 8'h0C;
    localparam logic [7:0] REG_FRAG_COUNT = 8'h10;

    // default fragment limit of 4 KiB
    localparam logic [27:0] MAX_MASK_RESET = 28'h000_0FFF;

    // request opcode
    // passed through untouched, never decoded here
    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1
    } req_opcode_e;

    // splitter fsm states
    typedef enum logic [1:0] {
        // waiting for a new request
        ST_IDLE  = 2'd0,
        // computing the next fragment
        ST_ISSUE = 2'd1,
        // fragment on the output, waiting for ready
        ST_WAIT  = 2'd2
    } split_state_e;

    // request descriptor, also used for the fragments
    typedef struct packed {
        req_opcode_e opcode;
        // destination stream
        logic [3:0]  dest;
        // process id
        logic [5:0]  pid;
        // final request of a transfer
        logic        last;
        // virtual byte address
        logic [47:0] vaddr;
        // length in bytes
        logic [27:0] len;
    } req_t;

    // apb request, master to slave
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // apb response, slave to master
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// File: logic/req_queue.sv
`timescale 1ns/100ps
`default_nettype none

// circular buffer fifo between the host stream and the splitter
module req_queue (
    input  wire logic              aclk,
    input  wire logic              aresetn,

    // write side
    input  wire logic              in_valid,
    input  wire dma_req_pkg::req_t in_data,
    output logic                   in_ready,

    // read side
    output logic                   out_valid,
    output dma_req_pkg::req_t      out_data,
    input  wire logic              out_ready,

    // current occupancy
    output logic [2:0]             count
);

    import dma_req_pkg::*;

    typedef logic [$clog2(QUEUE_DEPTH)-1:0] ptr_t;

    // storage, no reset on the payload
    req_t mem [QUEUE_DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;

    // handshakes on both sides
    logic push;
    logic pop;

    // full blocks the input even while popping
    assign in_ready  = (count != 3'(QUEUE_DEPTH));
    assign out_valid = (count != 3'd0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    // entry write
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap at the last entry
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // occupancy, unchanged on simultaneous push and pop
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            count <= 3'd0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 3'd1;
                2'b01:   count <= count - 3'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/request_splitter.sv
`timescale 1ns/100ps
`default_nettype none

// cuts one request into fragments of at most mask + 1 bytes
module request_splitter (
    input  wire logic              aclk,
    input  wire logic              aresetn,

    // configuration
    input  wire logic [27:0]       max_len_mask,
    input  wire logic              enable,

    // request in, from the queue head
    input  wire logic              in_valid,
    input  wire dma_req_pkg::req_t in_data,
    output logic                   in_ready,

    // fragment out
    output logic                   out_valid,
    output dma_req_pkg::req_t      out_data,
    input  wire logic              out_ready,

    // event pulses and activity
    output logic                   req_taken,
    output logic                   frag_sent,
    output logic                   busy
);

    import dma_req_pkg::*;

    split_state_e state;

    // one bit wider so an all ones mask still works
    logic [28:0]  max_len;

    // latched request header
    req_opcode_e  hold_opcode;
    logic [3:0]   hold_dest;
    logic [5:0]   hold_pid;
    logic         hold_last;

    // progress through the current request
    logic [47:0]  base_addr;
    logic [27:0]  remaining;

    // next fragment
    logic         final_frag;
    logic [27:0]  frag_len;

    assign max_len = {1'b0, max_len_mask} + 29'd1;

    // rest fits in one fragment, zero length included
    assign final_frag = ({1'b0, remaining} <= max_len);
    // max_len fits 28 bits whenever it is not the final piece
    assign frag_len   = final_frag ? remaining : max_len[27:0];

    // new takes only when idle and enabled
    assign in_ready  = (state == ST_IDLE) & enable;
    assign req_taken = in_valid & in_ready;
    assign frag_sent = out_valid & out_ready;
    assign busy      = (state != ST_IDLE);

    // control part of the fsm
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state     <= ST_IDLE;
            out_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_taken) begin
                        state <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    // fragment registered this cycle
                    out_valid <= 1'b1;
                    state     <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (out_ready) begin
                        out_valid <= 1'b0;
                        // bytes left means another fragment
                        state     <= (remaining != 28'd0) ? ST_ISSUE : ST_IDLE;
                    end
                end
                default: begin
                    out_valid <= 1'b0;
                    state     <= ST_IDLE;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge aclk) begin
        if (req_taken) begin
            hold_opcode <= in_data.opcode;
            hold_dest   <= in_data.dest;
            hold_pid    <= in_data.pid;
            hold_last   <= in_data.last;
            base_addr   <= in_data.vaddr;
            remaining   <= in_data.len;
        end else if (state == ST_ISSUE) begin
            out_data.opcode <= hold_opcode;
            out_data.dest   <= hold_dest;
            out_data.pid    <= hold_pid;
            // Last is only forwarded on the closing fragment of the request.
            out_data.last   <= hold_last & final_frag;
            out_data.vaddr  <= base_addr;
            out_data.len    <= frag_len;
            // step past this fragment
            base_addr       <= base_addr + {20'd0, frag_len};
            remaining       <= remaining - frag_len;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_dma_req_frontend.sv
`timescale 1ns/100ps
`default_nettype none

// directed testbench for the dma request front end
module tb_dma_req_frontend;

    import dma_req_pkg::*;

    localparam int CLK_PERIOD = 20;
    // cycle budget per test
    // random test allows 32 fragments per request
    localparam int RAND_CYCLES    = 20 * (32 * 6 + 40);
    localparam int TIMEOUT_CYCLES = 300 + 300 + RAND_CYCLES + 400 + 400 + 200;

    logic     aclk = 1'b0;
    logic     aresetn;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     req_in_valid;
    logic     req_in_ready;
    req_t     req_in_data;
    logic     frag_valid;
    logic     frag_ready;
    req_t     frag_data;

    // expected fragments in order
    req_t        exp_q[$];
    logic [27:0] cur_mask;
    logic [31:0] lcg_state = 32'hdb6a_d26e;
    int          errors;
    int          tests_ok;
    int          tests_bad;
    int          reqs_sent;
    int          frags_seen;

    dma_req_frontend i_dut (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .req_in_valid (req_in_valid),
        .req_in_ready (req_in_ready),
        .req_in_data  (req_in_data),
        .frag_valid   (frag_valid),
        .frag_ready   (frag_ready),
        .frag_data    (frag_data)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("error: simulation timed out, the DUT stopped responding");
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // random opcode, dest and pid
    function automatic req_t make_req(input logic [47:0] vaddr, input logic [27:0] len,
                                      input logic last);
        req_t        r;
        logic [31:0] rnd;
        rnd      = next_random();
        r.opcode = rnd[0] ? OP_WRITE : OP_READ;
        r.dest   = rnd[7:4];
        r.pid    = rnd[13:8];
        r.last   = last;
        r.vaddr  = vaddr;
        r.len    = len;
        return r;
    endfunction

    // reference model appending the fragments of one request
    function automatic void build_frags(input req_t r, input logic [27:0] mask);
        logic [28:0] max_len;
        logic [27:0] rem;
        logic [27:0] n;
        logic [47:0] addr;
        req_t        f;
        max_len = {1'b0, mask} + 29'd1;
        rem     = r.len;
        addr    = r.vaddr;
        // zero length still yields one fragment
        do begin
            n       = ({1'b0, rem} > max_len) ? max_len[27:0] : rem;
            f       = r;
            f.vaddr = addr;
            f.len   = n;
            f.last  = r.last && (rem == n);
            exp_q.push_back(f);
            addr = addr + {20'd0, n};
            rem  = rem - n;
        end while (rem != 28'd0);
    endfunction

    task automatic check(input logic [95:0] got, input logic [95:0] exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge aclk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge aclk);
        apb_req.penable = 1'b1;
        @(negedge aclk);
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        @(negedge aclk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        @(negedge aclk);
        apb_req.penable = 1'b1;
        // sampled while the access phase is still held
        @(negedge aclk);
        data    = apb_rsp.prdata;
        err     = apb_rsp.pslverr;
        check(apb_rsp.pready, 1'b1, "pready in access phase");
        apb_req = '0;
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] exp, input string msg);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check(data, exp, msg);
        check(err, 1'b0, {msg, " pslverr"});
    endtask

    task automatic set_mask(input logic [27:0] mask);
        apb_write(REG_MAX_MASK, {4'd0, mask});
        cur_mask = mask;
    endtask

    task automatic send_req(input req_t r);
        @(negedge aclk);
        req_in_valid = 1'b1;
        req_in_data  = r;
        while (!req_in_ready) @(negedge aclk);
        @(negedge aclk);
        req_in_valid = 1'b0;
        reqs_sent++;
    endtask

    // model the fragments before sending
    task automatic queue_req(input req_t r);
        build_frags(r, cur_mask);
        send_req(r);
    endtask

    task automatic expect_frag(input req_t exp);
        @(negedge aclk);
        frag_ready = 1'b1;
        while (!frag_valid) @(negedge aclk);
        check(frag_data, exp, "fragment");
        // transfer on the edge in between
        @(negedge aclk);
        frag_ready = 1'b0;
        frags_seen++;
    endtask

    task automatic drain_frags();
        req_t exp;
        while (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            expect_frag(exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
            tests_bad++;
        end
    endtask

    task automatic register_access();
        int          errs_before;
        logic [31:0] data;
        logic        err;
        errs_before = errors;
        read_check(REG_CTRL, 32'd1, "CTRL after reset");
        read_check(REG_MAX_MASK, {4'd0, MAX_MASK_RESET}, "MAX_MASK after reset");
        read_check(REG_STATUS, 32'd0, "STATUS after reset");
        read_check(REG_REQ_COUNT, 32'd0, "REQ_COUNT after reset");
        read_check(REG_FRAG_COUNT, 32'd0, "FRAG_COUNT after reset");
        set_mask(28'h5A5_A5A5);
        read_check(REG_MAX_MASK, 32'h05A5_A5A5, "MAX_MASK readback");
        // read-only register ignores the write
        apb_write(REG_REQ_COUNT, 32'hFFFF_FFFF);
        read_check(REG_REQ_COUNT, 32'd0, "REQ_COUNT after write");
        apb_read(8'h14, data, err);
        check(err, 1'b1, "pslverr on unmapped offset");
        set_mask(MAX_MASK_RESET);
        report_test("register_access", errs_before);
    endtask

    task automatic split_rules();
        int   errs_before;
        req_t r;
        req_t f;
        errs_before = errors;
        // 10000 bytes at mask 4095
        // two full fragments and a 1808 byte tail
        r = make_req(48'h1234_0000_0100, 28'd10000, 1'b1);
        f = r;
        f.len  = 28'd4096;
        f.last = 1'b0;
        exp_q.push_back(f);
        f.vaddr = 48'h1234_0000_1100;
        exp_q.push_back(f);
        f.vaddr = 48'h1234_0000_2100;
        f.len   = 28'd1808;
        f.last  = 1'b1;
        exp_q.push_back(f);
        send_req(r);
        drain_frags();
        // zero length and exactly max_len pass through as one fragment
        r = make_req(48'h0000_0000_2000, 28'd0, 1'b1);
        exp_q.push_back(r);
        send_req(r);
        r = make_req(48'h0000_0000_3000, 28'd4096, 1'b0);
        exp_q.push_back(r);
        send_req(r);
        drain_frags();
        report_test("split_rules", errs_before);
    endtask

    task automatic random_requests();
        int          errs_before;
        logic [27:0] mask;
        logic [27:0] len;
        logic [31:0] hi;
        logic [31:0] lo;
        errs_before = errors;
        for (int i = 0; i < 20; i++) begin
            // max_len from 256 up to 2048
            mask = 28'(next_random() % 2048) | 28'h0FF;
            set_mask(mask);
            hi  = next_random();
            lo  = next_random();
            len = 28'(next_random() % 8192);
            queue_req(make_req({hi[15:0], lo}, len, hi[31]));
            drain_frags();
        end
        set_mask(MAX_MASK_RESET);
        report_test("random_requests", errs_before);
    endtask

    task automatic back_pressure();
        int errs_before;
        errs_before = errors;
        // one held in the splitter and the rest in the queue
        for (int i = 0; i <= QUEUE_DEPTH; i++) begin
            queue_req(make_req(48'h0000_0010_0000 + 48'(i * 'h4000), 28'd6000, 1'b1));
        end
        check(req_in_ready, 1'b0, "req_in_ready with queue full");
        repeat (5) @(negedge aclk);
        check(req_in_ready, 1'b0, "req_in_ready still low under back-pressure");
        // four queued and the splitter busy
        read_check(REG_STATUS, 32'h0000_0041, "STATUS with splitter stalled");
        drain_frags();
        report_test("back_pressure", errs_before);
    endtask

    task automatic enable_gating();
        int errs_before;
        errs_before = errors;
        apb_write(REG_CTRL, 32'd0);
        for (int i = 0; i < 3; i++) begin
            queue_req(make_req(48'h0000_0020_0000 + 48'(i * 'h100), 28'd200, 1'b1));
        end
        repeat (8) @(negedge aclk);
        check(frag_valid, 1'b0, "frag_valid while disabled");
        // three queued with the splitter idle
        read_check(REG_STATUS, 32'h0000_0030, "STATUS while disabled");
        apb_write(REG_CTRL, 32'd1);
        drain_frags();
        report_test("enable_gating", errs_before);
    endtask

    task automatic counter_totals();
        int errs_before;
        errs_before = errors;
        repeat (4) @(negedge aclk);
        read_check(REG_REQ_COUNT, 32'(reqs_sent), "REQ_COUNT total");
        read_check(REG_FRAG_COUNT, 32'(frags_seen), "FRAG_COUNT total");
        read_check(REG_STATUS, 32'd0, "STATUS when idle");
        check(frag_valid, 1'b0, "no fragment left over");
        report_test("counter_totals", errs_before);
    endtask

    initial begin
        aresetn      = 1'b0;
        apb_req      = '0;
        req_in_valid = 1'b0;
        req_in_data  = '0;
        frag_ready   = 1'b0;
        cur_mask     = MAX_MASK_RESET;
        errors       = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        reqs_sent    = 0;
        frags_seen   = 0;
        repeat (3) @(negedge aclk);
        aresetn = 1'b1;
        register_access();
        split_rules();
        random_requests();
        back_pressure();
        enable_gating();
        counter_totals();
        $display("tests ok %0d, tests failed %0d, failed checks %0d", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
